//--- source/mps_pkg.sv
`default_nettype none

package mps_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus and register map

	localparam int DATA_W = 32;
	localparam int REG_W = 2;

	// Register offset within a channel, word address bits [1:0]
	typedef enum logic [REG_W-1:0] {
		REG_DATA    = 2'd0,
		REG_STATUS  = 2'd1,
		REG_DIVISOR = 2'd2,
		REG_IRQ_EN  = 2'd3
	} reg_sel_e;

	localparam int DIVISOR_W = 16;
	localparam logic [DIVISOR_W-1:0] DEFAULT_DIVISOR = 16'd16;

	//////////////////////////////////////////////////////////////////////
	// Write word views

	typedef struct packed {
		logic [23:0] rsvd;
		logic [7:0]  tx_byte;
	} tx_view_t;

	// Also the layout of an IRQ_EN read
	typedef struct packed {
		logic [13:0]          rsvd;
		logic                 rx_ready_en;
		logic                 tx_idle_en;
		logic [DIVISOR_W-1:0] divisor;
	} cfg_view_t;

	typedef union packed {
		tx_view_t  tx_view;
		cfg_view_t cfg_view;
	} wr_word_u;

	//////////////////////////////////////////////////////////////////////
	// Internal buses

	// Wishbone request, adr is the word address (byte address [31:2])
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [29:0] adr;
		wr_word_u    dat;
	} wb_req_t;

	typedef struct packed {
		logic     valid;
		logic     we;
		reg_sel_e reg_sel;
		wr_word_u wr_data;
	} port_cmd_t;

	// Low bits of a STATUS read, tx_busy is bit 2
	typedef struct packed {
		logic tx_busy;
		logic rx_valid;
		logic rx_overrun;
	} port_status_t;

endpackage

`default_nettype wire

//--- source/mps_bus_decode.sv
`timescale 1ns/10ps
`default_nettype none

module mps_bus_decode #(
	parameter int PORT_NUM = 4,
	localparam int IDX_W = (PORT_NUM > 1) ? $clog2(PORT_NUM) : 1
) (
	input  logic                               clk_i,
	input  logic                               rst_n_i,

	// Wishbone classic slave side
	input  mps_pkg::wb_req_t                   wb_req_i,
	output logic                               wb_ack_o,

	// Per channel commands
	output mps_pkg::port_cmd_t [PORT_NUM-1:0]  port_cmd_o,
	output logic [IDX_W-1:0]                   port_idx_o
);

	logic              req;
	logic [IDX_W-1:0]  idx;
	mps_pkg::reg_sel_e reg_sel;

	//////////////////////////////////////////////////////////////////////
	// Request detection and address split

	// New cycle only while ack is low, so a held stb is not taken twice
	assign req = wb_req_i.cyc & wb_req_i.stb & ~wb_ack_o;

	// Word address: register in the low bits, channel right above
	assign reg_sel = mps_pkg::reg_sel_e'(wb_req_i.adr[mps_pkg::REG_W-1:0]);
	assign idx = wb_req_i.adr[mps_pkg::REG_W +: IDX_W];

	assign port_idx_o = idx;

	//////////////////////////////////////////////////////////////////////
	// Acknowledge

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= req;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Command fan out

	// Every channel sees the register select so its read word follows
	// the address, only the addressed one gets valid
	for (genvar p = 0; p < PORT_NUM; p++) begin : g_cmd
		assign port_cmd_o[p].valid = req && (idx == IDX_W'(p));
		assign port_cmd_o[p].we = wb_req_i.we;
		assign port_cmd_o[p].reg_sel = reg_sel;
		assign port_cmd_o[p].wr_data = wb_req_i.dat;
	end

endmodule

`default_nettype wire

//--- source/uart_port.sv
`timescale 1ns/10ps
`default_nettype none

module uart_port (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  mps_pkg::port_cmd_t          cmd_i,
	output logic [mps_pkg::DATA_W-1:0]  rd_data_o,
	output logic                        irq_o,
	input  logic                        uart_rx_i,
	output logic                        uart_tx_o
);

	logic wr_en;
	logic rd_en;
	logic data_wr;
	logic data_rd;
	logic status_rd;

	// Configuration
	logic [mps_pkg::DIVISOR_W-1:0] divisor;
	logic                          rx_ready_en;
	logic                          tx_idle_en;

	// Transmitter
	logic                          tx_busy;
	logic [9:0]                    tx_shift;
	logic [3:0]                    tx_bit_cnt;
	logic [mps_pkg::DIVISOR_W-1:0] tx_baud_cnt;

	// Receiver
	logic [1:0]                    rx_sync;
	logic                          rx_prev;
	logic                          rx_active;
	logic [3:0]                    rx_bit_cnt;
	logic [mps_pkg::DIVISOR_W-1:0] rx_baud_cnt;
	logic [mps_pkg::DIVISOR_W-1:0] rx_target;
	logic                          rx_sample;
	logic                          rx_done;
	logic [7:0]                    rx_shift;
	logic [7:0]                    rx_data;
	logic                          rx_valid;
	logic                          rx_overrun;

	mps_pkg::port_status_t         status;
	mps_pkg::wr_word_u             irq_en_word;

	assign wr_en = cmd_i.valid & cmd_i.we;
	assign rd_en = cmd_i.valid & ~cmd_i.we;
	assign data_wr = wr_en && (cmd_i.reg_sel == mps_pkg::REG_DATA);
	assign data_rd = rd_en && (cmd_i.reg_sel == mps_pkg::REG_DATA);
	assign status_rd = rd_en && (cmd_i.reg_sel == mps_pkg::REG_STATUS);

	//////////////////////////////////////////////////////////////////////
	// Configuration registers

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			divisor <= mps_pkg::DEFAULT_DIVISOR;
			rx_ready_en <= 1'b0;
			tx_idle_en <= 1'b0;
		end else if (wr_en) begin
			case (cmd_i.reg_sel)
				mps_pkg::REG_DIVISOR: divisor <= cmd_i.wr_data.cfg_view.divisor;
				mps_pkg::REG_IRQ_EN: begin
					rx_ready_en <= cmd_i.wr_data.cfg_view.rx_ready_en;
					tx_idle_en <= cmd_i.wr_data.cfg_view.tx_idle_en;
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Transmitter, 8N1 LSB first

	// Writes while busy are dropped
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			tx_busy <= 1'b0;
			tx_shift <= '1;
			tx_bit_cnt <= '0;
			tx_baud_cnt <= '0;
		end else if (!tx_busy) begin
			if (data_wr) begin
				tx_busy <= 1'b1;
				tx_shift <= {1'b1, cmd_i.wr_data.tx_view.tx_byte, 1'b0};
				tx_bit_cnt <= '0;
				tx_baud_cnt <= '0;
			end
		end else if (tx_baud_cnt == divisor - 1'b1) begin
			tx_baud_cnt <= '0;
			tx_shift <= {1'b1, tx_shift[9:1]};
			tx_bit_cnt <= tx_bit_cnt + 4'd1;
			// End of stop bit
			if (tx_bit_cnt == 4'd9) begin
				tx_busy <= 1'b0;
			end
		end else begin
			tx_baud_cnt <= tx_baud_cnt + 1'b1;
		end
	end

	// Shift register idles at all ones
	assign uart_tx_o = tx_shift[0];

	//////////////////////////////////////////////////////////////////////
	// Receiver

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
		end else begin
			rx_sync <= {rx_sync[0], uart_rx_i};
			rx_prev <= rx_sync[1];
		end
	end

	// Half a bit to the middle of the start bit, then whole bits
	assign rx_target = (rx_bit_cnt == 4'd0) ? (divisor >> 1) : (divisor - 1'b1);
	assign rx_sample = rx_active && (rx_baud_cnt == rx_target);
	assign rx_done = rx_sample && (rx_bit_cnt == 4'd9) && rx_sync[1];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rx_active <= 1'b0;
			rx_bit_cnt <= '0;
			rx_baud_cnt <= '0;
		end else if (!rx_active) begin
			if (rx_prev && !rx_sync[1]) begin
				rx_active <= 1'b1;
				rx_bit_cnt <= '0;
				rx_baud_cnt <= '0;
			end
		end else if (rx_sample) begin
			rx_baud_cnt <= '0;
			rx_bit_cnt <= rx_bit_cnt + 4'd1;
			// Start bit gone high again is a glitch
			if ((rx_bit_cnt == 4'd0 && rx_sync[1]) || rx_bit_cnt == 4'd9) begin
				rx_active <= 1'b0;
			end
		end else begin
			rx_baud_cnt <= rx_baud_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rx_sample && rx_bit_cnt >= 4'd1 && rx_bit_cnt <= 4'd8) begin
			rx_shift <= {rx_sync[1], rx_shift[7:1]};
		end
		if (rx_done) begin
			rx_data <= rx_shift;
		end
	end

	// New byte wins over a read clear in the same cycle
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rx_valid <= 1'b0;
			rx_overrun <= 1'b0;
		end else begin
			if (data_rd) begin
				rx_valid <= 1'b0;
			end
			if (status_rd) begin
				rx_overrun <= 1'b0;
			end
			if (rx_done) begin
				rx_valid <= 1'b1;
				if (rx_valid && !data_rd) begin
					rx_overrun <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read word and interrupt

	assign status.tx_busy = tx_busy;
	assign status.rx_valid = rx_valid;
	assign status.rx_overrun = rx_overrun;

	always_comb begin
		irq_en_word = '0;
		irq_en_word.cfg_view.rx_ready_en = rx_ready_en;
		irq_en_word.cfg_view.tx_idle_en = tx_idle_en;
	end

	always_comb begin
		rd_data_o = '0;
		case (cmd_i.reg_sel)
			mps_pkg::REG_DATA: rd_data_o[7:0] = rx_data;
			mps_pkg::REG_STATUS: rd_data_o[$bits(status)-1:0] = status;
			mps_pkg::REG_DIVISOR: rd_data_o[mps_pkg::DIVISOR_W-1:0] = divisor;
			mps_pkg::REG_IRQ_EN: rd_data_o = irq_en_word;
			default: ;
		endcase
	end

	assign irq_o = (rx_ready_en & rx_valid) | (tx_idle_en & ~tx_busy);

endmodule

`default_nettype wire

//--- source/mps_readback.sv
`timescale 1ns/10ps
`default_nettype none

module mps_readback #(
	parameter int PORT_NUM = 4,
	localparam int IDX_W = (PORT_NUM > 1) ? $clog2(PORT_NUM) : 1
) (
	input  logic                                       clk_i,
	input  logic                                       rst_n_i,

	// From the decoder and the channels
	input  logic [IDX_W-1:0]                           port_idx_i,
	input  logic [PORT_NUM-1:0][mps_pkg::DATA_W-1:0]   port_rd_data_i,
	input  logic [PORT_NUM-1:0]                        port_irq_i,

	// To the bus
	output logic [mps_pkg::DATA_W-1:0]                 wb_dat_o,
	output logic                                       irq_o
);

	logic [mps_pkg::DATA_W-1:0] sel_word;

	//////////////////////////////////////////////////////////////////////
	// Read data select

	// Index past the last channel reads as zero
	always_comb begin
		sel_word = '0;
		for (int p = 0; p < PORT_NUM; p++) begin
			if (port_idx_i == IDX_W'(p)) begin
				sel_word = port_rd_data_i[p];
			end
		end
	end

	// Loaded on the same edge that raises ack
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_dat_o <= '0;
		end else begin
			wb_dat_o <= sel_word;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Interrupt combine

	// Level interrupt, any channel
	assign irq_o = |port_irq_i;

endmodule

`default_nettype wire

//--- source/mps_top.sv
`timescale 1ns/10ps
`default_nettype none

module mps_top #(
	parameter int PORT_NUM = 4,
	localparam int IDX_W = (PORT_NUM > 1) ? $clog2(PORT_NUM) : 1
) (
	input  logic                        clk_i,
	input  logic                        rst_n_i,

	// Wishbone classic slave
	input  logic                        wb_cyc_i,
	input  logic                        wb_stb_i,
	input  logic                        wb_we_i,
	input  logic [31:0]                 wb_adr_i,
	input  logic [mps_pkg::DATA_W-1:0]  wb_dat_i,
	output logic [mps_pkg::DATA_W-1:0]  wb_dat_o,
	output logic                        wb_ack_o,
	output logic                        irq_o,

	// Serial lines
	input  logic [PORT_NUM-1:0]         uart_rx_i,
	output logic [PORT_NUM-1:0]         uart_tx_o
);

	mps_pkg::wb_req_t                             wb_req;
	mps_pkg::port_cmd_t [PORT_NUM-1:0]            port_cmd;
	logic [IDX_W-1:0]                             port_idx;
	logic [PORT_NUM-1:0][mps_pkg::DATA_W-1:0]     port_rd_data;
	logic [PORT_NUM-1:0]                          port_irq;

	// Byte lane bits of the address are dropped
	assign wb_req.cyc = wb_cyc_i;
	assign wb_req.stb = wb_stb_i;
	assign wb_req.we = wb_we_i;
	assign wb_req.adr = wb_adr_i[31:2];
	assign wb_req.dat = wb_dat_i;

	mps_bus_decode #(
		.PORT_NUM(PORT_NUM)
	) mps_bus_decode_i (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.wb_req_i(wb_req),
		.wb_ack_o(wb_ack_o),
		.port_cmd_o(port_cmd),
		.port_idx_o(port_idx)
	);

	//////////////////////////////////////////////////////////////////////
	// Serial channels

	for (genvar p = 0; p < PORT_NUM; p++) begin : g_port
		uart_port uart_port_i (
			.clk_i(clk_i),
			.rst_n_i(rst_n_i),
			.cmd_i(port_cmd[p]),
			.rd_data_o(port_rd_data[p]),
			.irq_o(port_irq[p]),
			.uart_rx_i(uart_rx_i[p]),
			.uart_tx_o(uart_tx_o[p])
		);
	end

	mps_readback #(
		.PORT_NUM(PORT_NUM)
	) mps_readback_i (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.port_idx_i(port_idx),
		.port_rd_data_i(port_rd_data),
		.port_irq_i(port_irq),
		.wb_dat_o(wb_dat_o),
		.irq_o(irq_o)
	);

endmodule

`default_nettype wire

//--- verification/mps_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mps_tb;

	localparam int PORT_NUM = 4;
	localparam int CLK_PERIOD = 10;
	localparam int DEFAULT_DIV = 16;
	localparam int TEST_DIV = 8;
	localparam int LIMIT = 64;
	// 17 frames in all: transmit 4, receive 1, overrun 2, irq 2, random 8
	localparam int FRAME_NS = 10 * TEST_DIV * CLK_PERIOD;
	localparam int WATCHDOG_NS = 2 * 17 * FRAME_NS + 50000;

	localparam logic [1:0] REG_DATA = 2'd0;
	localparam logic [1:0] REG_STATUS = 2'd1;
	localparam logic [1:0] REG_DIVISOR = 2'd2;
	localparam logic [1:0] REG_IRQ_EN = 2'd3;
	localparam logic [31:0] ST_TX_BUSY = 32'h4;
	localparam logic [31:0] ST_RX_VALID = 32'h2;
	localparam logic [31:0] ST_RX_BOTH = 32'h3;
	localparam logic [31:0] RX_READY_EN = 32'h2_0000;
	localparam logic [31:0] TX_IDLE_EN = 32'h1_0000;

	logic                clk = 1'b0;
	logic                rst_n;
	logic                wb_cyc;
	logic                wb_stb;
	logic                wb_we;
	logic [31:0]         wb_adr;
	logic [31:0]         wb_dat_w;
	logic [31:0]         wb_dat_r;
	logic                wb_ack;
	logic                irq;
	logic [PORT_NUM-1:0] uart_rx;
	logic [PORT_NUM-1:0] uart_tx;
	int                  errors;
	integer              seed;

	mps_top #(
		.PORT_NUM(PORT_NUM)
	) DUT (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i(wb_we),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_dat_o(wb_dat_r),
		.wb_ack_o(wb_ack),
		.irq_o(irq),
		.uart_rx_i(uart_rx),
		.uart_tx_o(uart_tx)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Bus and serial line helpers

	task automatic report_mismatch(input string name, input int ch,
			input logic [31:0] expected, input logic [31:0] actual);
		errors++;
		$display("[ERROR] %0d ns ch%0d %s expected %h actual %h", $time, ch, name,
			expected, actual);
	endtask

	// One classic cycle, byte address is channel in [5:4], register in [3:2]
	task automatic bus_cycle(input logic we, input int ch, input logic [1:0] sel,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int cycles;
		@(posedge clk);
		#1;
		// Previous ack lasts one cycle only
		if (wb_ack) begin
			errors++;
			$display("Acknowledge still high before channel %0d register %0d", ch, sel);
		end
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = (32'(ch) << 4) | (32'(sel) << 2);
		wb_dat_w = wdata;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (!wb_ack && cycles < LIMIT);
		if (!wb_ack) begin
			errors++;
			$display("No acknowledge from channel %0d register %0d", ch, sel);
		end else if (cycles != 1) begin
			errors++;
			$display("Acknowledge from channel %0d register %0d after %0d cycles, not 1",
				ch, sel, cycles);
		end
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input int ch, input logic [1:0] sel, input logic [31:0] data);
		logic [31:0] ignored;
		bus_cycle(1'b1, ch, sel, data, ignored);
	endtask

	task automatic wb_read(input int ch, input logic [1:0] sel, output logic [31:0] data);
		bus_cycle(1'b0, ch, sel, 32'h0, data);
	endtask

	task automatic poll_status(input int ch, input logic [31:0] mask,
			input logic [31:0] want, output logic [31:0] value);
		int reads;
		reads = 0;
		do begin
			wb_read(ch, REG_STATUS, value);
			reads++;
		end while ((value & mask) != want && reads < LIMIT);
		if ((value & mask) != want) begin
			errors++;
			$display("Channel %0d STATUS never reached %h under mask %h", ch, want, mask);
		end
	endtask

	task automatic serial_send(input int ch, input int div, input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		@(posedge clk);
		#1;
		for (int b = 0; b < 10; b++) begin
			uart_rx[ch] = frame[b];
			repeat (div) @(posedge clk);
			#1;
		end
	endtask

	// Sampled on falling clock edges, away from the line changes
	task automatic serial_capture(input int ch, input int div, output logic [9:0] frame);
		int idle;
		idle = 0;
		@(negedge clk);
		while (uart_tx[ch] && idle < 4 * LIMIT) begin
			@(negedge clk);
			idle++;
		end
		if (uart_tx[ch]) begin
			errors++;
			$display("No start bit seen on channel %0d", ch);
		end
		repeat (div / 2) @(negedge clk);
		for (int b = 0; b < 10; b++) begin
			frame[b] = uart_tx[ch];
			if (b < 9) repeat (div) @(negedge clk);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests

	task automatic reset_and_registers();
		logic [31:0] value;
		if (irq !== 1'b0) report_mismatch("irq_o", 0, 32'h0, 32'(irq));
		if (uart_tx !== '1) report_mismatch("uart_tx_o", 0, 32'hF, 32'(uart_tx));
		for (int ch = 0; ch < PORT_NUM; ch++) begin
			wb_read(ch, REG_STATUS, value);
			if (value !== 32'h0) report_mismatch("STATUS", ch, 32'h0, value);
			wb_read(ch, REG_DIVISOR, value);
			if (value !== DEFAULT_DIV) report_mismatch("DIVISOR", ch, DEFAULT_DIV, value);
			wb_read(ch, REG_IRQ_EN, value);
			if (value !== 32'h0) report_mismatch("IRQ_EN", ch, 32'h0, value);
		end
		// Distinct values per channel catch aliasing
		for (int ch = 0; ch < PORT_NUM; ch++) begin
			wb_write(ch, REG_DIVISOR, 32'h30 + 32'(ch) * 32'h111);
			wb_write(ch, REG_IRQ_EN, 32'(ch & 3) << 16);
		end
		for (int ch = 0; ch < PORT_NUM; ch++) begin
			wb_read(ch, REG_DIVISOR, value);
			if (value !== 32'h30 + 32'(ch) * 32'h111)
				report_mismatch("DIVISOR", ch, 32'h30 + 32'(ch) * 32'h111, value);
			wb_read(ch, REG_IRQ_EN, value);
			if (value !== 32'(ch & 3) << 16)
				report_mismatch("IRQ_EN", ch, 32'(ch & 3) << 16, value);
			wb_write(ch, REG_IRQ_EN, 32'h0);
		end
	endtask

	task automatic transmit_frames();
		logic [9:0]  frame;
		logic [7:0]  sent;
		logic [31:0] value;
		for (int ch = 0; ch < PORT_NUM; ch++) wb_write(ch, REG_DIVISOR, TEST_DIV);
		for (int ch = 0; ch < PORT_NUM; ch++) begin
			sent = 8'hA5 ^ 8'(ch * 8'h3C);
			fork
				serial_capture(ch, TEST_DIV, frame);
				begin
					wb_write(ch, REG_DATA, 32'(sent));
					wb_read(ch, REG_STATUS, value);
					if (value !== ST_TX_BUSY)
						report_mismatch("STATUS busy", ch, ST_TX_BUSY, value);
					// Dropped, the channel is busy
					wb_write(ch, REG_DATA, 32'(~sent));
				end
			join
			if (frame !== {1'b1, sent, 1'b0})
				report_mismatch("uart_tx_o frame", ch, 32'({1'b1, sent, 1'b0}), 32'(frame));
			poll_status(ch, ST_TX_BUSY, 32'h0, value);
			if (value !== 32'h0) report_mismatch("STATUS idle", ch, 32'h0, value);
			if (uart_tx !== '1) report_mismatch("uart_tx_o idle", ch, 32'hF, 32'(uart_tx));
		end
	endtask

	task automatic receive_frame();
		logic [31:0] value;
		serial_send(1, TEST_DIV, 8'h6B);
		poll_status(1, ST_RX_VALID, ST_RX_VALID, value);
		wb_read(1, REG_DATA, value);
		if (value !== 32'h6B) report_mismatch("DATA", 1, 32'h6B, value);
		wb_read(1, REG_STATUS, value);
		if (value !== 32'h0) report_mismatch("STATUS after read", 1, 32'h0, value);
		for (int ch = 0; ch < PORT_NUM; ch++) begin
			wb_read(ch, REG_STATUS, value);
			if (value !== 32'h0) report_mismatch("STATUS other", ch, 32'h0, value);
		end
	endtask

	task automatic overrun_flag();
		logic [31:0] value;
		serial_send(3, TEST_DIV, 8'h12);
		serial_send(3, TEST_DIV, 8'hE7);
		poll_status(3, ST_RX_BOTH, ST_RX_BOTH, value);
		if (value !== ST_RX_BOTH) report_mismatch("STATUS overrun", 3, ST_RX_BOTH, value);
		wb_read(3, REG_DATA, value);
		if (value !== 32'hE7) report_mismatch("DATA", 3, 32'hE7, value);
		wb_read(3, REG_STATUS, value);
		if (value !== 32'h0) report_mismatch("STATUS cleared", 3, 32'h0, value);
	endtask

	task automatic interrupt_lines();
		logic [9:0]  frame;
		logic [31:0] value;
		wb_write(2, REG_IRQ_EN, RX_READY_EN);
		if (irq !== 1'b0) report_mismatch("irq_o no byte", 2, 32'h0, 32'(irq));
		serial_send(2, TEST_DIV, 8'h5A);
		poll_status(2, ST_RX_VALID, ST_RX_VALID, value);
		if (irq !== 1'b1) report_mismatch("irq_o rx ready", 2, 32'h1, 32'(irq));
		wb_read(2, REG_DATA, value);
		if (value !== 32'h5A) report_mismatch("DATA", 2, 32'h5A, value);
		if (irq !== 1'b0) report_mismatch("irq_o after read", 2, 32'h0, 32'(irq));
		wb_write(2, REG_IRQ_EN, 32'h0);
		wb_write(1, REG_IRQ_EN, TX_IDLE_EN);
		if (irq !== 1'b1) report_mismatch("irq_o tx idle", 1, 32'h1, 32'(irq));
		fork
			serial_capture(1, TEST_DIV, frame);
			begin
				wb_write(1, REG_DATA, 32'h3C);
				if (irq !== 1'b0) report_mismatch("irq_o tx busy", 1, 32'h0, 32'(irq));
			end
		join
		if (frame !== {1'b1, 8'h3C, 1'b0})
			report_mismatch("uart_tx_o frame", 1, 32'({1'b1, 8'h3C, 1'b0}), 32'(frame));
		poll_status(1, ST_TX_BUSY, 32'h0, value);
		if (irq !== 1'b1) report_mismatch("irq_o idle again", 1, 32'h1, 32'(irq));
		wb_write(1, REG_IRQ_EN, 32'h0);
	endtask

	task automatic random_traffic();
		int          ch;
		logic [7:0]  sent;
		logic [9:0]  frame;
		logic [31:0] value;
		for (int round = 0; round < 8; round++) begin
			ch = $random(seed) & 3;
			sent = 8'($random(seed));
			if (round % 2 == 0) begin
				fork
					serial_capture(ch, TEST_DIV, frame);
					wb_write(ch, REG_DATA, 32'(sent));
				join
				if (frame !== {1'b1, sent, 1'b0})
					report_mismatch("uart_tx_o frame", ch, 32'({1'b1, sent, 1'b0}), 32'(frame));
				poll_status(ch, ST_TX_BUSY, 32'h0, value);
			end else begin
				serial_send(ch, TEST_DIV, sent);
				poll_status(ch, ST_RX_VALID, ST_RX_VALID, value);
				wb_read(ch, REG_DATA, value);
				if (value !== 32'(sent)) report_mismatch("DATA", ch, 32'(sent), value);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sequence and watchdog

	initial begin
		errors = 0;
		seed = 35;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 32'h0;
		wb_dat_w = 32'h0;
		uart_rx = '1;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_and_registers();
		transmit_frames();
		receive_frame();
		overrun_flag();
		interrupt_lines();
		random_traffic();
		@(posedge clk);
		$display("Tests finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
source/mps_pkg.sv
source/mps_bus_decode.sv
source/uart_port.sv
source/mps_readback.sv
source/mps_top.sv
verification/mps_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the Verilator simulation, status from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module mps_tb --Mdir obj_dir -o mps_tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mps_tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0
